//--- hw/pe_pkg.sv
// shared lane widths, mode and number-type enums for the dot-product PE; import where needed
`default_nettype none

package pe_pkg;

    // ====================
    // operand word layout
    // ====================

    // one lane of an operand word
    localparam int LANE_WD = 16;

    // lane 0 1-bit, lane 1 2-bit, lane 2 4-bit
    localparam int MASK_WD = 3 * LANE_WD;

    // signed sum of one item, 4-bit lane spans -480 to 900
    localparam int SUM_WD = 11;

    // ====================
    // control encodings
    // ====================

    // element precision and 1-bit rule
    typedef enum logic [1:0] {
        MODE_XNOR = 2'd0,
        MODE_M1   = 2'd1,
        MODE_M2   = 2'd2,
        MODE_M4   = 2'd3
    } pe_mode_e;

    // how an operand field is extended
    typedef enum logic {
        NUM_UNSIGNED = 1'b0,
        NUM_SIGNED   = 1'b1
    } pe_numt_e;

endpackage

`default_nettype wire

//--- hw/pe_adder_tree.sv
// balanced pairwise adder tree; sums NUM packed elements into one OUT_WD-bit signed total
`timescale 1ns/1ps
`default_nettype none

module pe_adder_tree #(
    parameter int ELEM_WD = 5,
    parameter int NUM     = 8,
    parameter int OUT_WD  = 8
) (
    input  wire signed [NUM-1:0][ELEM_WD-1:0] i_elems,
    output logic signed [OUT_WD-1:0]          o_total
);
    // leaf count padded to a power of two
    localparam int NUM_P = 1 << $clog2(NUM);

    // heap layout, node n has children 2n+1 and 2n+2
    logic signed [OUT_WD-1:0] node [2*NUM_P-1];

    for (genvar k = 0; k < NUM_P; k++) begin : g_leaf
        if (k >= NUM) begin : g_pad
            assign node[NUM_P-1+k] = '0;
        end else if (ELEM_WD == 1) begin : g_bit
            // single bits count as 0 or 1
            assign node[NUM_P-1+k] = OUT_WD'(i_elems[k]);
        end else begin : g_sext
            assign node[NUM_P-1+k] = OUT_WD'($signed(i_elems[k]));
        end
    end

    for (genvar n = 0; n < NUM_P-1; n++) begin : g_node
        assign node[n] = node[2*n+1] + node[2*n+2];
    end

    assign o_total = node[0];

endmodule

`default_nettype wire

//--- hw/pe_arith_unit.sv
// masked lane multiply and reduction of one pixel/weight pair; registered sum with rdy/ack
`timescale 1ns/1ps
`default_nettype none

module pe_arith_unit (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_work,
    input  wire pe_pkg::pe_mode_e        i_mode,
    input  wire pe_pkg::pe_numt_e        i_inumt,
    input  wire pe_pkg::pe_numt_e        i_wnumt,
    input  wire [pe_pkg::MASK_WD-1:0]    i_mask,
    input  wire [pe_pkg::MASK_WD-1:0]    i_pix,
    input  wire                          i_pix_rdy,
    input  wire [pe_pkg::MASK_WD-1:0]    i_wgt,
    input  wire                          i_wgt_rdy,
    output logic                         o_pix_ack,
    output logic                         o_wgt_ack,
    output logic signed [pe_pkg::SUM_WD-1:0] o_sum,
    output logic                         o_sum_rdy,
    input  wire                          i_sum_ack
);
    import pe_pkg::*;

    // ====================
    // lane shapes
    // ====================
    localparam int N2     = LANE_WD / 2;
    localparam int N4     = LANE_WD / 4;
    localparam int POP_WD = $clog2(LANE_WD) + 1;
    // 3x3 and 5x5 signed products
    localparam int P2_WD  = 5;
    localparam int P4_WD  = 9;
    localparam int S2_WD  = 8;

    logic [MASK_WD-1:0] pix_m;
    logic [MASK_WD-1:0] wgt_m;
    logic [LANE_WD-1:0] pix_l0, pix_l1, pix_l2;
    logic [LANE_WD-1:0] wgt_l0, wgt_l1, wgt_l2;

    logic [LANE_WD-1:0]          prod1;
    logic [N2-1:0][P2_WD-1:0]    prod2;
    logic [N4-1:0][P4_WD-1:0]    prod4;

    logic [POP_WD-1:0]           pop1;
    logic signed [S2_WD-1:0]     sum2;
    logic signed [SUM_WD-1:0]    sum4;
    logic signed [SUM_WD-1:0]    pop_s;
    logic signed [SUM_WD-1:0]    sum_w;

    logic signed [SUM_WD-1:0]    sum_r;
    logic                        sum_rdy;
    logic                        accept;

    assign pix_m = i_pix & i_mask;
    assign wgt_m = i_wgt & i_mask;

    assign pix_l0 = pix_m[0*LANE_WD +: LANE_WD];
    assign pix_l1 = pix_m[1*LANE_WD +: LANE_WD];
    assign pix_l2 = pix_m[2*LANE_WD +: LANE_WD];
    assign wgt_l0 = wgt_m[0*LANE_WD +: LANE_WD];
    assign wgt_l1 = wgt_m[1*LANE_WD +: LANE_WD];
    assign wgt_l2 = wgt_m[2*LANE_WD +: LANE_WD];

    // ====================
    // element products
    // ====================
    always_comb begin
        logic signed [2:0] px2, wg2;
        logic signed [4:0] px4, wg4;
        for (int i = 0; i < LANE_WD; i++) begin
            if (i_mode == MODE_XNOR) begin
                prod1[i] = ~(pix_l0[i] ^ wgt_l0[i]);
            end else begin
                prod1[i] = pix_l0[i] & wgt_l0[i];
            end
        end
        // msb copied only for signed operands
        for (int i = 0; i < N2; i++) begin
            px2 = {(i_inumt == NUM_SIGNED) & pix_l1[2*i+1], pix_l1[2*i +: 2]};
            wg2 = {(i_wnumt == NUM_SIGNED) & wgt_l1[2*i+1], wgt_l1[2*i +: 2]};
            prod2[i] = px2 * wg2;
        end
        for (int i = 0; i < N4; i++) begin
            px4 = {(i_inumt == NUM_SIGNED) & pix_l2[4*i+3], pix_l2[4*i +: 4]};
            wg4 = {(i_wnumt == NUM_SIGNED) & wgt_l2[4*i+3], wgt_l2[4*i +: 4]};
            prod4[i] = px4 * wg4;
        end
    end

    pe_adder_tree #(.ELEM_WD(1), .NUM(LANE_WD), .OUT_WD(POP_WD)) u_tree1 (
        .i_elems (prod1),
        .o_total (pop1)
    );

    pe_adder_tree #(.ELEM_WD(P2_WD), .NUM(N2), .OUT_WD(S2_WD)) u_tree2 (
        .i_elems (prod2),
        .o_total (sum2)
    );

    pe_adder_tree #(.ELEM_WD(P4_WD), .NUM(N4), .OUT_WD(SUM_WD)) u_tree4 (
        .i_elems (prod4),
        .o_total (sum4)
    );

    // popcount reaches 16, so read it as unsigned
    assign pop_s = {{(SUM_WD-POP_WD){1'b0}}, pop1};

    always_comb begin
        case (i_mode)
            MODE_XNOR: sum_w = (pop_s <<< 1) - SUM_WD'(LANE_WD);
            MODE_M1:   sum_w = pop_s;
            MODE_M2:   sum_w = SUM_WD'(sum2);
            default:   sum_w = sum4;
        endcase
    end

    // ====================
    // handshake and sum register
    // ====================

    // take a pair when the slot is empty or draining this cycle, never in reset
    assign accept    = !i_rst && i_work && i_pix_rdy && i_wgt_rdy && (!sum_rdy || i_sum_ack);
    assign o_pix_ack = accept;
    assign o_wgt_ack = accept;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sum_r   <= '0;
            sum_rdy <= 1'b0;
        end else if (i_work) begin
            if (accept) begin
                sum_r <= sum_w;
            end
            sum_rdy <= accept || (sum_rdy && !i_sum_ack);
        end
    end

    assign o_sum     = sum_r;
    assign o_sum_rdy = sum_rdy;

    a_ack_needs_rdy : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_pix_ack || o_wgt_ack) |-> (i_pix_rdy && i_wgt_rdy && i_work));

    a_sum_held : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_sum_rdy && !i_sum_ack) |=> (o_sum_rdy && $stable(o_sum)));

endmodule

`default_nettype wire

//--- hw/pe_accumulator.sv
// sums runs of arithmetic-unit results and presents each run total behind rdy/ack
`timescale 1ns/1ps
`default_nettype none

module pe_accumulator #(
    parameter int ACC_WD = 20,
    parameter int LEN_WD = 8
) (
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire                              i_work,
    input  wire [LEN_WD-1:0]                 i_acc_len,
    input  wire signed [pe_pkg::SUM_WD-1:0]  i_sum,
    input  wire                              i_sum_rdy,
    output logic                             o_sum_ack,
    output logic signed [ACC_WD-1:0]         o_acc,
    output logic                             o_acc_rdy,
    input  wire                              i_acc_ack
);
    import pe_pkg::*;

    logic [LEN_WD-1:0]        run_cnt;
    logic [LEN_WD-1:0]        run_len;
    logic signed [ACC_WD-1:0] run_sum;
    logic signed [ACC_WD-1:0] acc_r;
    logic                     acc_rdy;

    logic                     first;
    logic                     last;
    logic [LEN_WD-1:0]        len_cur;
    logic [LEN_WD-1:0]        cnt_nxt;
    logic signed [ACC_WD-1:0] total;

    // stall while a finished total waits in the slot
    assign o_sum_ack = i_work && i_sum_rdy && (!acc_rdy || i_acc_ack);

    // ====================
    // run bookkeeping
    // ====================
    assign first   = (run_cnt == '0);
    assign len_cur = first ? i_acc_len : run_len;
    assign cnt_nxt = run_cnt + 1'b1;
    assign last    = (cnt_nxt == len_cur);
    assign total   = (first ? '0 : run_sum) + ACC_WD'(i_sum);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            run_cnt <= '0;
            run_len <= '0;
            run_sum <= '0;
        end else if (o_sum_ack) begin
            if (last) begin
                run_cnt <= '0;
                run_sum <= '0;
            end else begin
                run_cnt <= cnt_nxt;
                run_sum <= total;
            end
            // length is fixed for the whole run
            if (first) begin
                run_len <= i_acc_len;
            end
        end
    end

    // ====================
    // result slot
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc_r   <= '0;
            acc_rdy <= 1'b0;
        end else if (o_sum_ack && last) begin
            acc_r   <= total;
            acc_rdy <= 1'b1;
        end else if (i_acc_ack) begin
            // the consumer owns the transfer, even while frozen
            acc_rdy <= 1'b0;
        end
    end

    assign o_acc     = acc_r;
    assign o_acc_rdy = acc_rdy;

    a_acc_held : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_acc_rdy && !i_acc_ack) |=> (o_acc_rdy && $stable(o_acc)));

    a_len_nonzero : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_sum_ack && run_cnt == '0) |-> (i_acc_len != '0));

endmodule

`default_nettype wire

//--- hw/pe_top.sv
// top of the dot-product processing element; arithmetic unit feeding the run accumulator
`timescale 1ns/1ps
`default_nettype none

module pe_top #(
    parameter int ACC_WD = 20,
    parameter int LEN_WD = 8
) (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_work,
    input  wire pe_pkg::pe_mode_e        i_mode,
    input  wire pe_pkg::pe_numt_e        i_inumt,
    input  wire pe_pkg::pe_numt_e        i_wnumt,
    input  wire [pe_pkg::MASK_WD-1:0]    i_mask,
    input  wire [LEN_WD-1:0]             i_acc_len,
    input  wire [pe_pkg::MASK_WD-1:0]    i_pix,
    input  wire                          i_pix_rdy,
    output logic                         o_pix_ack,
    input  wire [pe_pkg::MASK_WD-1:0]    i_wgt,
    input  wire                          i_wgt_rdy,
    output logic                         o_wgt_ack,
    output logic signed [ACC_WD-1:0]     o_acc,
    output logic                         o_acc_rdy,
    input  wire                          i_acc_ack
);
    import pe_pkg::*;

    // per-item sum between the two stages
    logic signed [SUM_WD-1:0] au_sum;
    logic                     au_sum_rdy;
    logic                     au_sum_ack;

    pe_arith_unit u_arith (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_work    (i_work),
        .i_mode    (i_mode),
        .i_inumt   (i_inumt),
        .i_wnumt   (i_wnumt),
        .i_mask    (i_mask),
        .i_pix     (i_pix),
        .i_pix_rdy (i_pix_rdy),
        .i_wgt     (i_wgt),
        .i_wgt_rdy (i_wgt_rdy),
        .o_pix_ack (o_pix_ack),
        .o_wgt_ack (o_wgt_ack),
        .o_sum     (au_sum),
        .o_sum_rdy (au_sum_rdy),
        .i_sum_ack (au_sum_ack)
    );

    pe_accumulator #(.ACC_WD(ACC_WD), .LEN_WD(LEN_WD)) u_acc (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_work    (i_work),
        .i_acc_len (i_acc_len),
        .i_sum     (au_sum),
        .i_sum_rdy (au_sum_rdy),
        .o_sum_ack (au_sum_ack),
        .o_acc     (o_acc),
        .o_acc_rdy (o_acc_rdy),
        .i_acc_ack (i_acc_ack)
    );

endmodule

`default_nettype wire

//--- tb/pe_tb.sv
// testbench for pe_top; random operand runs checked by assertions against a lane-level model
`timescale 1ns/1ps
`default_nettype none

module pe_tb;
    import pe_pkg::*;

    localparam int ACC_WD = 20;
    localparam int LEN_WD = 8;
    // items per test: 1-bit, 2/4-bit, run length, back-pressure
    localparam int TEST_ITEMS = 48 + 64 + 63 + 36;
    localparam int WATCHDOG_CYCLES = (TEST_ITEMS + 100) * 4;

    logic i_clk, i_rst, i_work, i_pix_rdy, i_wgt_rdy, i_acc_ack;
    pe_mode_e i_mode;
    pe_numt_e i_inumt, i_wnumt;
    logic [MASK_WD-1:0] i_mask, i_pix, i_wgt;
    logic [LEN_WD-1:0] i_acc_len;
    wire o_pix_ack, o_wgt_ack, o_acc_rdy;
    wire signed [ACC_WD-1:0] o_acc;

    int seed = 19;
    int exp_q[$];
    int exp_head, fail_cnt, results, runs_sent, tests_ok, tests_bad;
    int run_sum, run_cnt, mark_fail, mark_runs, mark_res;
    // 0 ack always high, 1 alternating, 2 random
    int ack_mode;
    bit freeze, head_valid, xfer_pend;
    logic signed [ACC_WD-1:0] acc_prev, acc_now;

    pe_top #(.ACC_WD(ACC_WD), .LEN_WD(LEN_WD)) uut (
        .i_clk(i_clk), .i_rst(i_rst), .i_work(i_work), .i_mode(i_mode),
        .i_inumt(i_inumt), .i_wnumt(i_wnumt), .i_mask(i_mask), .i_acc_len(i_acc_len),
        .i_pix(i_pix), .i_pix_rdy(i_pix_rdy), .o_pix_ack(o_pix_ack),
        .i_wgt(i_wgt), .i_wgt_rdy(i_wgt_rdy), .o_wgt_ack(o_wgt_ack),
        .o_acc(o_acc), .o_acc_rdy(o_acc_rdy), .i_acc_ack(i_acc_ack)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // ====================
    // reference model
    // ====================
    function automatic int field(logic [MASK_WD-1:0] w, int lsb, int bits, pe_numt_e nt);
        int v;
        v = 0;
        for (int k = 0; k < bits; k++) begin
            if (w[lsb+k]) v += 1 << k;
        end
        if (nt == NUM_SIGNED && v >= (1 << (bits - 1))) v -= 1 << bits;
        return v;
    endfunction

    function automatic int item_value(pe_mode_e mode, pe_numt_e inumt, pe_numt_e wnumt,
                                      logic [MASK_WD-1:0] mask, logic [MASK_WD-1:0] pix,
                                      logic [MASK_WD-1:0] wgt);
        logic [MASK_WD-1:0] pm, wm;
        int total;
        pm = pix & mask;
        wm = wgt & mask;
        total = 0;
        for (int i = 0; i < 16; i++) begin
            if (mode == MODE_XNOR) total += (pm[i] == wm[i]) ? 2 : 0;
            if (mode == MODE_M1) total += (pm[i] && wm[i]) ? 1 : 0;
        end
        if (mode == MODE_XNOR) total -= 16;
        for (int i = 0; i < 8 && mode == MODE_M2; i++) begin
            total += field(pm, 16 + 2*i, 2, inumt) * field(wm, 16 + 2*i, 2, wnumt);
        end
        for (int i = 0; i < 4 && mode == MODE_M4; i++) begin
            total += field(pm, 32 + 4*i, 4, inumt) * field(wm, 32 + 4*i, 4, wnumt);
        end
        return total;
    endfunction

    function automatic logic [MASK_WD-1:0] rand_word();
        logic [31:0] hi, lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi[15:0], lo};
    endfunction

    // ====================
    // stimulus
    // ====================
    task automatic send_item(input pe_mode_e mode, input pe_numt_e inumt, input pe_numt_e wnumt,
                             input logic [MASK_WD-1:0] mask, input logic [MASK_WD-1:0] pix,
                             input logic [MASK_WD-1:0] wgt);
        i_mode = mode;
        i_inumt = inumt;
        i_wnumt = wnumt;
        i_mask = mask;
        i_pix = pix;
        i_wgt = wgt;
        i_pix_rdy = 1'b1;
        i_wgt_rdy = 1'b1;
        @(negedge i_clk);
        while (!(o_pix_ack && o_wgt_ack)) @(negedge i_clk);
        @(posedge i_clk);
        #1;
        i_pix_rdy = 1'b0;
        i_wgt_rdy = 1'b0;
        run_sum += item_value(mode, inumt, wnumt, mask, pix, wgt);
        run_cnt++;
        if (run_cnt == int'(i_acc_len)) begin
            exp_q.push_back(run_sum);
            runs_sent++;
            run_sum = 0;
            run_cnt = 0;
        end
    endtask

    // mode_pick and numt_pick above 3 mean random per item
    task automatic run_items(input int len, input int runs, input int mode_pick,
                             input int numt_pick, input bit full_mask);
        logic [31:0] r;
        pe_mode_e mode;
        pe_numt_e inumt, wnumt;
        logic [MASK_WD-1:0] mask;
        i_acc_len = LEN_WD'(len);
        for (int n = 0; n < len * runs; n++) begin
            r = $random(seed);
            mode = (mode_pick < 4) ? pe_mode_e'(mode_pick) : pe_mode_e'(r[1:0]);
            inumt = (numt_pick < 4) ? pe_numt_e'(numt_pick[1]) : pe_numt_e'(r[2]);
            wnumt = (numt_pick < 4) ? pe_numt_e'(numt_pick[0]) : pe_numt_e'(r[3]);
            mask = full_mask ? '1 : rand_word();
            send_item(mode, inumt, wnumt, mask, rand_word(), rand_word());
        end
        while (exp_q.size() != 0 || xfer_pend) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    // result consumer and work enable, drawn at negedge and applied after the edge
    always begin
        logic [31:0] r;
        int mode_now;
        bit freeze_now;
        @(negedge i_clk);
        r = $random(seed);
        mode_now = ack_mode;
        freeze_now = freeze;
        @(posedge i_clk);
        #1;
        case (mode_now)
            0: i_acc_ack = 1'b1;
            1: i_acc_ack = ~i_acc_ack;
            default: i_acc_ack = r[0];
        endcase
        i_work = freeze_now ? (r[2:1] != 2'b00) : 1'b1;
    end

    // ====================
    // result scoreboard and checks
    // ====================
    always @(negedge i_clk) begin
        if (xfer_pend) begin
            results++;
            if (exp_q.size() > 0) exp_q.delete(0);
        end
        xfer_pend = o_acc_rdy && i_acc_ack && !i_rst;
        head_valid = (exp_q.size() > 0);
        exp_head = head_valid ? exp_q[0] : 0;
        acc_prev = acc_now;
        acc_now = o_acc;
    end

    a_reset_quiet : assert property (@(posedge i_clk)
        $past(i_rst) |-> (!o_pix_ack && !o_wgt_ack && !o_acc_rdy))
        else begin
            $display("ERROR at %0t: handshake outputs active during reset", $time);
            fail_cnt++;
        end

    a_acks_frozen : assert property (@(posedge i_clk) !i_work |-> (!o_pix_ack && !o_wgt_ack))
        else begin
            $display("ERROR at %0t: operand ack raised while i_work is low", $time);
            fail_cnt++;
        end

    a_acc_held : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_acc_rdy && !i_acc_ack) |=> (o_acc_rdy && $stable(o_acc)))
        else begin
            $display("CHECK FAILED at %0t: o_acc expected %0d got %0d", $time, acc_prev, acc_now);
            fail_cnt++;
        end

    a_result_expected : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_acc_rdy && i_acc_ack) |-> head_valid)
        else begin
            $display("ERROR at %0t: a result was delivered with no run outstanding", $time);
            fail_cnt++;
        end

    a_acc_value : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_acc_rdy && i_acc_ack && head_valid) |-> (o_acc == exp_head))
        else begin
            $display("CHECK FAILED at %0t: o_acc expected %0d got %0d",
                     $time, exp_head, $sampled(o_acc));
            fail_cnt++;
        end

    // ====================
    // test sequence
    // ====================
    task automatic start_test();
        mark_fail = fail_cnt;
        mark_runs = runs_sent;
        mark_res = results;
    endtask

    task automatic end_test(input string name);
        int runs, got;
        runs = runs_sent - mark_runs;
        got = results - mark_res;
        if (got != runs) begin
            $display("CHECK FAILED at %0t: result count expected %0d got %0d", $time, runs, got);
            fail_cnt++;
        end
        if (fail_cnt == mark_fail) begin
            tests_ok++;
            $display("test %-13s ok, %0d results", name, got);
        end else begin
            tests_bad++;
            $display("test %-13s failed", name);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("ERROR: the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        i_work = 1'b1;
        i_mode = MODE_XNOR;
        i_inumt = NUM_UNSIGNED;
        i_wnumt = NUM_UNSIGNED;
        i_mask = '0;
        i_pix = '0;
        i_wgt = '0;
        i_acc_len = LEN_WD'(1);
        // a pair already waits while reset is held
        i_pix_rdy = 1'b1;
        i_wgt_rdy = 1'b1;
        i_acc_ack = 1'b0;
        ack_mode = 0;
        freeze = 1'b0;
        start_test();
        repeat (4) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        i_pix_rdy = 1'b0;
        i_wgt_rdy = 1'b0;
        repeat (3) @(posedge i_clk);
        #1;
        end_test("reset");

        start_test();
        run_items(1, 24, 0, 4, 1'b1);
        run_items(1, 24, 1, 4, 1'b1);
        end_test("1-bit modes");

        start_test();
        for (int m = 2; m < 4; m++) begin
            for (int t = 0; t < 4; t++) begin
                run_items(1, 8, m, t, 1'b0);
            end
        end
        end_test("2/4-bit");

        start_test();
        ack_mode = 1;
        run_items(1, 3, 4, 4, 1'b0);
        run_items(3, 3, 4, 4, 1'b0);
        run_items(17, 3, 4, 4, 1'b0);
        end_test("run length");

        start_test();
        ack_mode = 2;
        freeze = 1'b1;
        run_items(3, 12, 4, 4, 1'b0);
        freeze = 1'b0;
        ack_mode = 0;
        end_test("backpressure");

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_ok, tests_bad, fail_cnt);
        if (fail_cnt == 0 && tests_bad == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pe.f
hw/pe_pkg.sv
hw/pe_adder_tree.sv
hw/pe_arith_unit.sv
hw/pe_accumulator.sv
hw/pe_top.sv
tb/pe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the PE testbench with Verilator, run it into sim.log and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f pe.f --top-module pe_tb -o pe_sim \
    && ./obj_dir/pe_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
